// ==== tb.f ====
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_immgen.sv
hw/rv_execute.sv
hw/rv_regfile.sv
hw/rv_core.sv
test/tb_clock.sv
test/tb_top.sv

// ==== test/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import rv_pkg::*;

    logic clk, reset_n, mem_valid, mem_ready;
    logic [xlen-1:0] mem_addr, mem_wdata, mem_rdata;
    logic [strb_w-1:0] mem_wstrb;

    logic [31:0] mem [0:1023];     // 4 KB, program and data
    logic [31:0] exp_addr[$], exp_data[$];
    int test_errs[6], test_checks[6], stores_seen, emit_idx, st_off, marker;
    int unsigned lcg_state = 15;
    string test_names[6] = '{"reset state", "alu ops", "load/store and x0",
                             "branches", "jumps", "bus back-pressure"};

    tb_clock clk_gen (.clk(clk), .reset_n(reset_n));

    rv_core dut_i (
        .clk(clk), .reset_n(reset_n), .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    task automatic check(string name, logic [31:0] got, logic [31:0] exp, int t);
        test_checks[t]++;
        if (got !== exp) begin
            test_errs[t]++;
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    function automatic int lcg_next();
        lcg_state = lcg_state * 1103515245 + 12345;
        return (lcg_state >> 16) % 4; // 0 to 3 wait cycles
    endfunction

    // ------------------------------------------------------------------------
    // instruction encoders
    // ------------------------------------------------------------------------
    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
    endfunction
    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
    endfunction
    function automatic logic [31:0] enc_b(int imm, int rs1, int rs2, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
    endfunction
    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic void emit(logic [31:0] w);
        mem[emit_idx] = w;
        emit_idx++;
    endfunction

    function automatic void emit_alu_store(logic [31:0] w);
        emit(w);                       // result lands in x4
        emit(enc_s(st_off, 4, 10));
        st_off += 4;
    endfunction

    // taken path stores marker + 0x100, fall-through stores marker
    function automatic void emit_branch_case(int f3, int rs1, int rs2);
        emit(enc_i(marker, 0, 0, 20, opc_op_imm));
        emit(enc_b(12, rs1, rs2, f3));
        emit(enc_s(st_off, 20, 12));
        emit(enc_j(12, 0));
        emit(enc_i(256, 20, 0, 20, opc_op_imm));
        emit(enc_s(st_off, 20, 12));
        st_off += 4;
        marker++;
    endfunction

    // golden model, walks the image and queues every store in order
    function automatic void run_golden();
        logic [31:0] g [0:1023];
        logic [31:0] x [32];
        logic [31:0] pc, ins, a, b, op2, imm_i, imm_s, imm_b, imm_j, res, nxt;
        logic [2:0] f3;
        logic wr, tk;
        g = mem;
        foreach (x[i]) x[i] = '0;
        pc = 0;
        for (int n = 0; n < 4000; n++) begin
            ins = g[pc[11:2]];
            if (ins == enc_j(0, 0)) break; // halt loop
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            f3 = ins[14:12];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            op2 = (ins[6:0] == opc_op) ? b : imm_i;
            nxt = pc + 4;
            wr = 1'b1;
            res = pc + 4; // link value
            case (ins[6:0])
                opc_op_imm, opc_op: begin
                    case (f3)
                        3'd0: res = (ins[6:0] == opc_op && ins[30]) ? a - op2 : a + op2;
                        3'd1: res = a << op2[4:0];
                        3'd2: res = {31'b0, $signed(a) < $signed(op2)};
                        3'd3: res = {31'b0, a < op2};
                        3'd4: res = a ^ op2;
                        3'd5: begin
                            if (ins[30]) begin
                                res = $signed(a) >>> op2[4:0]; // sign fill
                            end else begin
                                res = a >> op2[4:0];
                            end
                        end
                        3'd6: res = a | op2;
                        default: res = a & op2;
                    endcase
                end
                opc_lui: res = {ins[31:12], 12'b0};
                opc_load: res = g[(a + imm_i) >> 2];
                opc_store: begin
                    wr = 1'b0;
                    g[(a + imm_s) >> 2] = b;
                    exp_addr.push_back(a + imm_s);
                    exp_data.push_back(b);
                end
                opc_branch: begin
                    wr = 1'b0;
                    case (f3)
                        3'd0: tk = (a == b);
                        3'd1: tk = (a != b);
                        3'd4: tk = ($signed(a) < $signed(b));
                        3'd5: tk = ($signed(a) >= $signed(b));
                        3'd6: tk = (a < b);
                        default: tk = (a >= b);
                    endcase
                    if (tk) nxt = pc + imm_b;
                end
                opc_jal: nxt = pc + imm_j;
                opc_jalr: nxt = (a + imm_i) & ~32'd1;
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 0) x[ins[11:7]] = res;
            pc = nxt;
        end
    endfunction

    // ------------------------------------------------------------------------
    // program image
    // ------------------------------------------------------------------------
    initial begin
        int q;
        for (int i = 0; i < 1024; i++) mem[i] = (i * 4) ^ 32'h5a5a_0000; // whole-address fill
        emit_idx = 0;
        st_off = 0;
        emit(enc_i(12'h400, 0, 0, 10, opc_op_imm)); // x10 = alu result base, above the code
        emit(enc_i(-5, 0, 0, 1, opc_op_imm));
        emit(enc_i(7, 0, 0, 2, opc_op_imm));
        emit({20'h12345, 5'd3, opc_lui});
        emit_alu_store({20'h12345, 5'd4, opc_lui});
        for (int f = 0; f < 8; f++) emit_alu_store(enc_r(0, 2, 1, f, 4));
        emit_alu_store(enc_r(32, 2, 1, 0, 4)); // sub
        emit_alu_store(enc_r(32, 2, 1, 5, 4)); // sra
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) emit_alu_store(enc_i(4, 1, f, 4, opc_op_imm));
            else emit_alu_store(enc_i(-1371 + f * 7, 1, f, 4, opc_op_imm));
        end
        emit_alu_store(enc_i(12'h404, 1, 5, 4, opc_op_imm)); // srai
        // store, load back, modify, store; then x0
        emit(enc_i(12'h500, 0, 0, 11, opc_op_imm));
        emit(enc_s(0, 3, 11));
        emit(enc_i(0, 11, 2, 5, opc_load));
        emit(enc_i(1, 5, 0, 5, opc_op_imm));
        emit(enc_s(4, 5, 11));
        emit(enc_i(99, 0, 0, 0, opc_op_imm));
        emit(enc_s(8, 0, 11));
        // branches, taken then not taken
        emit(enc_i(12'h600, 0, 0, 12, opc_op_imm));
        st_off = 0;
        marker = 16;
        emit_branch_case(0, 1, 1);
        emit_branch_case(0, 1, 2);
        emit_branch_case(1, 1, 2);
        emit_branch_case(1, 1, 1);
        emit_branch_case(4, 1, 2);
        emit_branch_case(4, 2, 1);
        emit_branch_case(5, 2, 1);
        emit_branch_case(5, 1, 2);
        emit_branch_case(6, 2, 1);
        emit_branch_case(6, 1, 2);
        emit_branch_case(7, 1, 2);
        emit_branch_case(7, 2, 1);
        // jal, then jalr to an odd address
        emit(enc_i(12'h700, 0, 0, 13, opc_op_imm));
        emit(enc_j(8, 6));
        emit(enc_s(12'h0f0, 0, 13)); // skipped
        emit(enc_s(0, 6, 13));
        q = emit_idx * 4;
        emit(enc_i(q + 13, 0, 0, 7, opc_op_imm));
        emit(enc_i(0, 7, 0, 8, opc_jalr));
        emit(enc_s(8, 0, 13)); // skipped
        emit(enc_s(4, 8, 13));
        emit(enc_j(0, 0)); // halt
        run_golden();
    end

    // ------------------------------------------------------------------------
    // memory model and store compare
    // ------------------------------------------------------------------------
    logic [31:0] cur_addr, cur_wdata, st_addr, st_wdata;
    logic [3:0]  cur_wstrb, st_wstrb;
    logic        cur_valid, busy, first_done, bus_live;
    int          delay;

    task automatic compare_store(logic [31:0] a, logic [31:0] d);
        int t;
        stores_seen++;
        t = (a >> 8) - 3; // 0x400 region is test 2 (index 1)
        if (t < 1 || t > 4) t = 5;
        if (exp_addr.size() == 0) begin
            test_errs[t]++;
            $display("unexpected store at t=%0t to %h", $time, a);
        end else begin
            check("mem_addr", a, exp_addr.pop_front(), t);
            check("mem_wdata", d, exp_data.pop_front(), t);
        end
    endtask

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        busy = 1'b0;
        first_done = 1'b0;
        bus_live = 1'b0;
        forever begin
            @(posedge clk);
            bus_live = reset_n; // reset level the dut saw on this edge
            if (busy && mem_ready) begin // transfer done on this edge
                if (!first_done) begin
                    check("mem_addr", cur_addr, 32'h0, 0);
                    check("mem_wstrb", cur_wstrb, 4'h0, 0);
                    first_done = 1'b1;
                end
                check("mem_addr", cur_addr, st_addr, 5);
                check("mem_wstrb", cur_wstrb, st_wstrb, 5);
                if (cur_wstrb != 0) begin
                    check("mem_wdata", cur_wdata, st_wdata, 5);
                    mem[cur_addr[11:2]] = cur_wdata;
                    compare_store(cur_addr, cur_wdata);
                end
                busy = 1'b0;
            end
            #1;
            cur_valid = mem_valid;
            cur_addr = mem_addr;
            cur_wdata = mem_wdata;
            cur_wstrb = mem_wstrb;
            mem_ready = 1'b0;
            if (bus_live && cur_valid) begin
                if (!busy) begin // request just raised
                    busy = 1'b1;
                    st_addr = cur_addr;
                    st_wdata = cur_wdata;
                    st_wstrb = cur_wstrb;
                    delay = lcg_next();
                end
                if (delay == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = mem[cur_addr[11:2]];
                end else begin
                    delay--;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // run control and report
    // ------------------------------------------------------------------------
    initial begin
        int cyc, total_err, total_chk, expected;
        bit timed_out;
        timed_out = 1'b0;
        cyc = 0;
        while (reset_n !== 1'b1 && cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if (reset_n !== 1'b1) begin
            $display("reset_n never released");
            timed_out = 1'b1;
        end
        expected = exp_addr.size();
        cyc = 0;
        while (!timed_out && stores_seen < expected && cyc < 20000) begin
            @(posedge clk);
            cyc++;
        end
        if (stores_seen < expected) begin
            $display("timed out waiting for stores, %0d of %0d seen", stores_seen, expected);
            timed_out = 1'b1;
        end
        repeat (4) @(posedge clk);
        total_err = 0;
        total_chk = 0;
        for (int t = 0; t < 6; t++) begin
            if (t == 5) test_errs[5] += test_errs[1] + test_errs[2] + test_errs[3] + test_errs[4];
            $display("test %0d %s: %s (%0d checks, %0d errors)", t + 1, test_names[t],
                     (test_errs[t] == 0 && test_checks[t] > 0) ? "ok" : "failed",
                     test_checks[t], test_errs[t]);
            total_chk += test_checks[t];
            total_err += (t == 5) ? test_errs[5] - test_errs[1] - test_errs[2]
                                    - test_errs[3] - test_errs[4] : test_errs[t];
        end
        $display("checks %0d, errors %0d, stores %0d of %0d", total_chk, total_err,
                 stores_seen, expected);
        if (total_err == 0 && !timed_out && test_checks[0] > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset_n
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1; // released just after the third edge
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                      clk,
    input  logic                      reset_n,
    output logic                      mem_valid,
    output logic [rv_pkg::xlen-1:0]   mem_addr,
    output logic [rv_pkg::xlen-1:0]   mem_wdata,
    output logic [rv_pkg::strb_w-1:0] mem_wstrb,
    input  logic                      mem_ready,
    input  logic [rv_pkg::xlen-1:0]   mem_rdata
);
    import rv_pkg::*;

    stage_t          stage_reg;
    logic [xlen-1:0] pc_reg;
    logic [xlen-1:0] instr_reg;  // fetched word
    logic [xlen-1:0] load_data;  // lw result

    // decode
    logic    reg_write, mem_write, mem_read;
    logic    alu_src_zero, alu_src_reg;
    alu_op_t alu_op;
    logic    branch, jump, jump_reg;

    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic [xlen-1:0]       rs1_data, rs2_data, rf_wdata;
    logic                  rf_we;
    logic [xlen-1:0]       alu_in1, alu_in2, alu_result;
    logic                  branch_taken;
    logic [xlen-1:0]       pc_plus4, pc_next;

    assign rs1 = instr_reg[19:15];
    assign rs2 = instr_reg[24:20];
    assign rd  = instr_reg[11:7];

    rv_decoder u_decoder (
        .instr(instr_reg), .reg_write(reg_write), .mem_write(mem_write),
        .mem_read(mem_read), .alu_src_zero(alu_src_zero), .alu_src_reg(alu_src_reg),
        .alu_op(alu_op), .branch(branch), .jump(jump), .jump_reg(jump_reg)
    );

    rv_immgen u_immgen (.instr(instr_reg), .imm(imm));

    rv_regfile u_regfile (
        .clk(clk), .reset_n(reset_n), .we(rf_we), .waddr(rd), .wdata(rf_wdata),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    assign alu_in1 = alu_src_zero ? '0 : rs1_data; // lui adds to zero
    assign alu_in2 = alu_src_reg ? rs2_data : imm;

    rv_execute u_execute (
        .in1(alu_in1), .in2(alu_in2), .alu_op(alu_op), .rs2_data(rs2_data),
        .funct3(instr_reg[14:12]), .alu_result(alu_result), .branch_taken(branch_taken)
    );

    // ------------------------------------------------------------------------
    // bus drive, by stage
    // ------------------------------------------------------------------------
    assign mem_valid = (stage_reg == stage_if) || (stage_reg == stage_mem);
    assign mem_addr  = (stage_reg == stage_mem) ? alu_result : pc_reg; // pc in fetch
    assign mem_wdata = (stage_reg == stage_mem && mem_write) ? rs2_data : '0;
    assign mem_wstrb = (stage_reg == stage_mem && mem_write) ? '1 : '0; // full word

    // writeback select and next pc
    assign pc_plus4 = pc_reg + 32'd4;
    assign rf_we    = (stage_reg == stage_wb) && reg_write;
    assign rf_wdata = mem_read ? load_data :
                      jump     ? pc_plus4  : // link
                                 alu_result;

    always_comb begin
        if (jump_reg) begin
            pc_next = alu_result & ~32'd1; // jalr drops bit 0
        end else if ((branch && branch_taken) || jump) begin
            pc_next = pc_reg + imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // stage controller
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage_reg <= stage_if;
            pc_reg    <= '0;
        end else begin
            case (stage_reg)
                stage_if: if (mem_ready) stage_reg <= stage_ex;
                stage_ex: stage_reg <= (mem_read || mem_write) ? stage_mem : stage_wb;
                stage_mem: if (mem_ready) stage_reg <= stage_wb;
                stage_wb: begin
                    pc_reg    <= pc_next;
                    stage_reg <= stage_if;
                end
                default: stage_reg <= stage_if;
            endcase
        end
    end

    // payload capture, no reset
    always_ff @(posedge clk) begin
        if (stage_reg == stage_if && mem_ready) instr_reg <= mem_rdata;
        if (stage_reg == stage_mem && mem_ready) load_data <= mem_rdata; // harmless on sw
    end

    // request held until accepted
    a_bus_stable: assert property (@(posedge clk) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wstrb));

    // no write strobe outside a request
    a_wstrb_valid: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_wstrb != '0) |-> mem_valid);

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]       wdata,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    // x0 reads zero whatever was written
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata; // end of writeback
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic [rv_pkg::xlen-1:0] in1,      // rs1 or zero
    input  logic [rv_pkg::xlen-1:0] in2,      // rs2 or imm
    input  rv_pkg::alu_op_t         alu_op,
    input  logic [rv_pkg::xlen-1:0] rs2_data, // compare operand
    input  logic [2:0]              funct3,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = in2[4:0];

    // ------------------------------------------------------------------------
    // alu
    // ------------------------------------------------------------------------
    always_comb begin
        case (alu_op)
            alu_add:  alu_result = in1 + in2;
            alu_sub:  alu_result = in1 - in2;
            alu_sll:  alu_result = in1 << shamt;
            alu_slt:  alu_result = {{(xlen - 1){1'b0}}, $signed(in1) < $signed(in2)};
            alu_sltu: alu_result = {{(xlen - 1){1'b0}}, in1 < in2};
            alu_xor:  alu_result = in1 ^ in2;
            alu_srl:  alu_result = in1 >> shamt;
            alu_sra:  alu_result = $unsigned($signed(in1) >>> shamt); // sign fill
            alu_or:   alu_result = in1 | in2;
            alu_and:  alu_result = in1 & in2;
            default:  alu_result = in1 + in2;
        endcase
    end

    // branch compare, independent of alu_op
    always_comb begin
        case (funct3)
            br_beq:  branch_taken = (in1 == rs2_data);
            br_bne:  branch_taken = (in1 != rs2_data);
            br_blt:  branch_taken = ($signed(in1) < $signed(rs2_data));
            br_bge:  branch_taken = ($signed(in1) >= $signed(rs2_data));
            br_bltu: branch_taken = (in1 < rs2_data);
            br_bgeu: branch_taken = (in1 >= rs2_data);
            default: branch_taken = 1'b0; // 010 / 011 not a branch
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_immgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_immgen (
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic       shift_imm; // slli, srli, srai

    assign opcode    = instr[6:0];
    assign shift_imm = (opcode == opc_op_imm) && (instr[13:12] == 2'b01); // funct3 001 / 101

    always_comb begin
        case (opcode)
            opc_lui:    imm = {instr[31:12], 12'b0}; // U
            opc_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // S
            opc_branch: imm = {{19{instr[31]}}, instr[31], instr[7],
                               instr[30:25], instr[11:8], 1'b0}; // B
            opc_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12],
                               instr[20], instr[30:21], 1'b0}; // J
            default: begin
                // I format, shifts keep just shamt
                if (shift_imm) begin
                    imm = {{(xlen - 5){1'b0}}, instr[24:20]};
                end else begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    mem_read,
    output logic                    alu_src_zero, // in1 = 0, lui
    output logic                    alu_src_reg,  // in2 = rs2, else imm
    output rv_pkg::alu_op_t         alu_op,
    output logic                    branch,
    output logic                    jump,         // jal and jalr
    output logic                    jump_reg      // jalr only
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5; // sub / sra select

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // ------------------------------------------------------------------------
    // control levels
    // ------------------------------------------------------------------------
    always_comb begin
        reg_write    = 1'b0;
        mem_write    = 1'b0;
        mem_read     = 1'b0;
        alu_src_zero = 1'b0;
        alu_src_reg  = 1'b0;
        branch       = 1'b0;
        jump         = 1'b0;
        jump_reg     = 1'b0;
        case (opcode)
            opc_op_imm: reg_write = 1'b1;
            opc_op: begin
                reg_write   = 1'b1;
                alu_src_reg = 1'b1;
            end
            opc_lui: begin
                reg_write    = 1'b1;
                alu_src_zero = 1'b1; // 0 + imm
            end
            opc_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            opc_store: mem_write = 1'b1;
            opc_branch: begin
                branch      = 1'b1;
                alu_src_reg = 1'b1;
            end
            opc_jal: begin
                reg_write = 1'b1; // link
                jump      = 1'b1;
            end
            opc_jalr: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                jump_reg  = 1'b1; // target from alu
            end
            default: ; // unknown opcode acts as nop
        endcase
    end

    // alu control
    always_comb begin
        alu_op = alu_add; // loads, stores, jumps, lui
        if (opcode == opc_branch) begin
            alu_op = alu_sub;
        end else if (opcode == opc_op || opcode == opc_op_imm) begin
            case (funct3)
                3'b000: alu_op = (opcode == opc_op && funct7_b5) ? alu_sub : alu_add;
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: alu_op = funct7_b5 ? alu_sra : alu_srl; // srai too
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int xlen       = 32; // data and address
    localparam int reg_addr_w = 5;  // register index
    localparam int num_regs   = 32;
    localparam int strb_w     = xlen / 8; // one strobe bit per byte

    // ------------------------------------------------------------------------
    // major opcodes, instr[6:0]
    // ------------------------------------------------------------------------
    localparam logic [6:0] opc_op_imm = 7'b0010011; // addi .. srai
    localparam logic [6:0] opc_op     = 7'b0110011; // register-register alu
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011; // lw only
    localparam logic [6:0] opc_store  = 7'b0100011; // sw only
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // branch funct3
    localparam logic [2:0] br_beq  = 3'b000;
    localparam logic [2:0] br_bne  = 3'b001;
    localparam logic [2:0] br_blt  = 3'b100; // signed
    localparam logic [2:0] br_bge  = 3'b101; // signed
    localparam logic [2:0] br_bltu = 3'b110;
    localparam logic [2:0] br_bgeu = 3'b111;

    // core stages, one instruction in flight
    typedef enum logic [1:0] {
        stage_if  = 2'd0, // fetch, bus active
        stage_ex  = 2'd1, // execute, single cycle
        stage_mem = 2'd2, // lw / sw, bus active
        stage_wb  = 2'd3  // writeback and pc update
    } stage_t;

endpackage

`default_nettype wire
